//--- pgl_input.txt
// Word 0 line count, then per segment: ystr_lft h_lft ystr_rgt h_rgt type colr
// Per line: kill_l kill_r yend_eq_l yend_eq_r, then csgb ystr_eq yend_csgb xstr xend for l, r
6
10 08 12 08 1 1
20 06 22 06 3 2
30 05 32 05 2 3
40 04 42 04 1 0
50 04 52 04 1 1
60 03 62 03 3 2
70 03 72 03 2 3
80 02 82 02 1 1
90 02 92 02 3 0
A0 01 A2 01 1 2
// Line records
0 0 0 0 0 1 1 004 00C 0 1 1 014 01C
0 0 1 0 0 0 1 006 012 0 0 1 00E 018
1 0 0 1 0 0 1 003 010 0 0 1 012 01E
0 1 0 0 1 0 1 005 00A 0 0 0 015 019
0 0 1 1 0 1 0 008 008 0 1 0 020 022
0 0 0 0 0 0 1 000 3FF 0 0 1 3FF 000

//--- sim.f
+incdir+include
hdl/pgl_pkg.sv
hdl/pgl_sync_if.sv
hdl/pgl_timing.sv
hdl/pgl_seg_track.sv
hdl/pgl_window.sv
hdl/pgl_ctrl.sv
bench/pgl_clk_gen.sv
bench/pgl_ctrl_asserts.sv
bench/pgl_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pgl_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module pgl_ctrl_tb -f sim.f -o pgl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/pgl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1

//--- bench/pgl_ctrl_tb.sv
`timescale 1ns/1ns
`include "pgl_macros.svh"

module pgl_ctrl_tb;

  import pgl_pkg::*;

  localparam int SEG      = `PGL_SEG;
  localparam int CLK_NS   = 20;
  localparam int LINE_PIX = 40;                  // Active cycles per line
  localparam int BLANK    = 6;                   // Idle cycles after hend
  localparam int LINE_CYC = LINE_PIX + BLANK + 2;
  localparam int REC_W    = 14;                  // Words per line record
  localparam int REC_BASE = 1 + 6 * SEG;
  localparam int MAX_REC  = (256 - REC_BASE) / REC_W;

  logic [15:0] vec [0:255];                      // Raw words from the input file
  int          n_lines = 0;

  logic pclk, prst_n;
  logic pgl_fstr_i, pgl_vstr_i, pgl_vend_i, pgl_hstr_i, pgl_hend_i, pgl_dvld_i;
  logic cu_yc_done_i;
  logic cu_lft_ystr_csgb_i, cu_lft_ystr_eq_i, cu_lft_yend_csgb_i, cu_lft_yend_eq_i;
  logic cu_rgt_ystr_csgb_i, cu_rgt_ystr_eq_i, cu_rgt_yend_csgb_i, cu_rgt_yend_eq_i;
  pgl_hcnt_t cu_lft_xstr_i, cu_lft_xend_i, cu_rgt_xstr_i, cu_rgt_xend_i;
  pgl_ystr_t [SEG-1:0] reg_ystr_lft_i, reg_ystr_rgt_i;
  pgl_h_t    [SEG-1:0] reg_h_lft_i, reg_h_rgt_i;
  pgl_code_t [SEG-1:0] reg_type_i, reg_colr_i;
  logic reg_kill_lft_i, reg_kill_rgt_i;
  logic pgl_vstr_o, pgl_vend_o, pgl_hstr_o, pgl_hend_o, pgl_dvld_o;
  pgl_hcnt_t pgl_hcnt_o;
  pgl_vcnt_t pgl_vcnt_o;
  pgl_ystr_t pgl_ystr_lft_o, pgl_ystr_rgt_o;
  pgl_h_t    pgl_h_lft_o, pgl_h_rgt_o;
  pgl_code_t pgl_type_lft_o, pgl_colr_lft_o, pgl_type_rgt_o, pgl_colr_rgt_o;
  logic pgl_vld_lft_o, pgl_vld_rgt_o, pgl_edge_o;

  // ----------------------------------------
  // Reference state, index 0 left, 1 right
  // ----------------------------------------
  logic [4:0]  hist1 = '0;                       // Strobes one cycle back {vstr,vend,hstr,hend,dvld}
  logic [4:0]  hist2 = '0;                       // Two cycles back
  pgl_hcnt_t   m_hcnt = '0;
  pgl_vcnt_t   m_vcnt = '0;
  pgl_seg_oh_t m_idx [2] = '{'0, '0};
  pgl_code_t   m_ln_type [2] = '{'0, '0};        // Type of the segment seen last cycle
  pgl_code_t   m_type [2] = '{'0, '0};
  pgl_code_t   m_colr [2] = '{'0, '0};
  logic        m_csgb [2] = '{1'b0, 1'b0};
  logic        m_eq [2] = '{1'b0, 1'b0};
  logic        m_yend [2] = '{1'b0, 1'b0};
  pgl_hcnt_t   m_xstr [2] = '{'0, '0};
  pgl_hcnt_t   m_xend [2] = '{'0, '0};

  string cur_test;
  int    test_errs = 0;
  int    err_total = 0;
  int    test_cnt = 0;
  int    test_fails = 0;
  int    checks_run = 0;

  pgl_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYC(3)) u_clk (.pclk, .prst_n);

  pgl_ctrl uut (.*);

  function automatic int seg_num(pgl_seg_oh_t idx);
    int n;
    n = -1;
    for (int i = 0; i < SEG; i++)
      if (idx[i]) n = i;
    return n;
  endfunction

  // Valid when kill off, type set, row inside segment and hcnt in x range
  function automatic logic window_open(int s);
    logic kill;
    kill = (s == 0) ? reg_kill_lft_i : reg_kill_rgt_i;
    return !kill && (m_type[s] != '0) && !m_csgb[s] && (m_yend[s] || m_eq[s]) &&
           (m_hcnt >= m_xstr[s]) && (m_hcnt <= m_xend[s]);
  endfunction

  task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    test_errs++;
  endtask

  task automatic begin_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    $display("Test %s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    test_cnt++;
    err_total += test_errs;
    if (test_errs != 0) test_fails++;
  endtask

  // Next reference state from the inputs about to be sampled
  task automatic advance_model();
    logic [4:0] strb;
    logic [1:0] adv;
    int         n;
    strb = {pgl_vstr_i, pgl_vend_i, pgl_hstr_i, pgl_hend_i, pgl_dvld_i};
    adv  = {cu_yc_done_i & cu_rgt_yend_eq_i, cu_yc_done_i & cu_lft_yend_eq_i};
    if (pgl_hstr_i || hist1[4])                  // Line start or vstr one cycle back
      m_hcnt = '0;
    else if (pgl_dvld_i || hist1[0])             // Each dvld counts for two cycles
      m_hcnt = m_hcnt + 10'd1;
    if (hist1[4])
      m_vcnt = '0;
    else if (pgl_hstr_i)
      m_vcnt = m_vcnt + 10'd1;
    for (int s = 0; s < 2; s++) begin
      n = seg_num(m_idx[s]);
      if (pgl_hend_i) begin
        m_type[s] = m_ln_type[s];                // Type lags color by one cycle
        m_colr[s] = (n < 0) ? '0 : reg_colr_i[n];
        m_csgb[s] = (s == 0) ? cu_lft_ystr_csgb_i : cu_rgt_ystr_csgb_i;
        m_eq[s]   = (s == 0) ? cu_lft_ystr_eq_i : cu_rgt_ystr_eq_i;
        m_yend[s] = (s == 0) ? cu_lft_yend_csgb_i : cu_rgt_yend_csgb_i;
        m_xstr[s] = (s == 0) ? cu_lft_xstr_i : cu_rgt_xstr_i;
        m_xend[s] = (s == 0) ? cu_lft_xend_i : cu_rgt_xend_i;
      end
      if (pgl_fstr_i) begin
        m_eq[s]   = 1'b0;
        m_yend[s] = 1'b0;
      end
      m_ln_type[s] = (n < 0) ? '0 : reg_type_i[n];
      m_idx[s] = (hist2[3] ? '0 : (adv[s] ? (m_idx[s] << 1) : m_idx[s])) |
                 {{(SEG-1){1'b0}}, pgl_fstr_i};  // vend_o clears, fstr picks segment 0
    end
    hist2 = hist1;
    hist1 = strb;
  endtask

  task automatic check_outputs();
    int        n [2];
    logic      vld [2];
    logic      e_edge;
    pgl_ystr_t e_ystr [2];
    pgl_h_t    e_h [2];
    n[0]      = seg_num(m_idx[0]);
    n[1]      = seg_num(m_idx[1]);
    e_ystr[0] = (n[0] < 0) ? '0 : reg_ystr_lft_i[n[0]];
    e_ystr[1] = (n[1] < 0) ? '0 : reg_ystr_rgt_i[n[1]];
    e_h[0]    = (n[0] < 0) ? '0 : reg_h_lft_i[n[0]];
    e_h[1]    = (n[1] < 0) ? '0 : reg_h_rgt_i[n[1]];
    vld[0]    = window_open(0);
    vld[1]    = window_open(1);
    // Inner bounds hidden where the windows overlap
    e_edge = (vld[0] && (m_hcnt == m_xstr[0] || (m_hcnt == m_xend[0] && !vld[1]))) ||
             (vld[1] && ((m_hcnt == m_xstr[1] && !vld[0]) || m_hcnt == m_xend[1]));
    checks_run++;
    if (pgl_vstr_o !== hist2[4]) mismatch("pgl_vstr_o", pgl_vstr_o, hist2[4]);
    if (pgl_vend_o !== hist2[3]) mismatch("pgl_vend_o", pgl_vend_o, hist2[3]);
    if (pgl_hstr_o !== hist2[2]) mismatch("pgl_hstr_o", pgl_hstr_o, hist2[2]);
    if (pgl_hend_o !== hist2[1]) mismatch("pgl_hend_o", pgl_hend_o, hist2[1]);
    if (pgl_dvld_o !== hist2[0]) mismatch("pgl_dvld_o", pgl_dvld_o, hist2[0]);
    if (pgl_hcnt_o !== m_hcnt) mismatch("pgl_hcnt_o", pgl_hcnt_o, m_hcnt);
    if (pgl_vcnt_o !== m_vcnt) mismatch("pgl_vcnt_o", pgl_vcnt_o, m_vcnt);
    if (pgl_ystr_lft_o !== e_ystr[0]) mismatch("pgl_ystr_lft_o", pgl_ystr_lft_o, e_ystr[0]);
    if (pgl_ystr_rgt_o !== e_ystr[1]) mismatch("pgl_ystr_rgt_o", pgl_ystr_rgt_o, e_ystr[1]);
    if (pgl_h_lft_o !== e_h[0]) mismatch("pgl_h_lft_o", pgl_h_lft_o, e_h[0]);
    if (pgl_h_rgt_o !== e_h[1]) mismatch("pgl_h_rgt_o", pgl_h_rgt_o, e_h[1]);
    if (pgl_type_lft_o !== m_type[0]) mismatch("pgl_type_lft_o", pgl_type_lft_o, m_type[0]);
    if (pgl_type_rgt_o !== m_type[1]) mismatch("pgl_type_rgt_o", pgl_type_rgt_o, m_type[1]);
    if (pgl_colr_lft_o !== m_colr[0]) mismatch("pgl_colr_lft_o", pgl_colr_lft_o, m_colr[0]);
    if (pgl_colr_rgt_o !== m_colr[1]) mismatch("pgl_colr_rgt_o", pgl_colr_rgt_o, m_colr[1]);
    if (pgl_vld_lft_o !== vld[0]) mismatch("pgl_vld_lft_o", pgl_vld_lft_o, vld[0]);
    if (pgl_vld_rgt_o !== vld[1]) mismatch("pgl_vld_rgt_o", pgl_vld_rgt_o, vld[1]);
    if (pgl_edge_o !== e_edge) mismatch("pgl_edge_o", pgl_edge_o, e_edge);
  endtask

  // Inputs already set at a falling edge, compare at the next one
  task automatic clock_step();
    advance_model();
    @(negedge pclk);
    check_outputs();
  endtask

  task automatic init_inputs();
    {pgl_fstr_i, pgl_vstr_i, pgl_vend_i, pgl_hstr_i, pgl_hend_i, pgl_dvld_i} = '0;
    cu_yc_done_i = 1'b0;
    {cu_lft_ystr_csgb_i, cu_lft_ystr_eq_i, cu_lft_yend_csgb_i, cu_lft_yend_eq_i} = '0;
    {cu_rgt_ystr_csgb_i, cu_rgt_ystr_eq_i, cu_rgt_yend_csgb_i, cu_rgt_yend_eq_i} = '0;
    {cu_lft_xstr_i, cu_lft_xend_i, cu_rgt_xstr_i, cu_rgt_xend_i} = '0;
    {reg_ystr_lft_i, reg_ystr_rgt_i, reg_h_lft_i, reg_h_rgt_i} = '0;
    {reg_type_i, reg_colr_i} = '0;
    {reg_kill_lft_i, reg_kill_rgt_i} = '0;
  endtask

  task automatic load_tables();
    for (int i = 0; i < SEG; i++) begin
      reg_ystr_lft_i[i] = vec[1 + 6 * i][`PGL_YSTR_W-1:0];
      reg_h_lft_i[i]    = vec[2 + 6 * i][`PGL_H_W-1:0];
      reg_ystr_rgt_i[i] = vec[3 + 6 * i][`PGL_YSTR_W-1:0];
      reg_h_rgt_i[i]    = vec[4 + 6 * i][`PGL_H_W-1:0];
      reg_type_i[i]     = vec[5 + 6 * i][`PGL_CODE_W-1:0];
      reg_colr_i[i]     = vec[6 + 6 * i][`PGL_CODE_W-1:0];
    end
  endtask

  task automatic load_record(int k);
    int a;
    a = REC_BASE + k * REC_W;
    reg_kill_lft_i     = vec[a][0];
    reg_kill_rgt_i     = vec[a + 1][0];
    cu_lft_yend_eq_i   = vec[a + 2][0];
    cu_rgt_yend_eq_i   = vec[a + 3][0];
    cu_lft_ystr_csgb_i = vec[a + 4][0];
    cu_lft_ystr_eq_i   = vec[a + 5][0];
    cu_lft_yend_csgb_i = vec[a + 6][0];
    cu_lft_xstr_i      = vec[a + 7][`PGL_XWID-1:0];
    cu_lft_xend_i      = vec[a + 8][`PGL_XWID-1:0];
    cu_rgt_ystr_csgb_i = vec[a + 9][0];
    cu_rgt_ystr_eq_i   = vec[a + 10][0];
    cu_rgt_yend_csgb_i = vec[a + 11][0];
    cu_rgt_xstr_i      = vec[a + 12][`PGL_XWID-1:0];
    cu_rgt_xend_i      = vec[a + 13][`PGL_XWID-1:0];
  endtask

  // One video line, CU results held as levels for the whole line
  task automatic run_line(int k);
    begin_test($sformatf("line %0d", k));
    load_record(k);
    pgl_hstr_i = 1'b1;
    clock_step();
    pgl_hstr_i = 1'b0;
    for (int c = 0; c < LINE_PIX; c++) begin
      pgl_dvld_i   = ($urandom() % 4) != 0;      // Random gaps in data valid
      cu_yc_done_i = (c == LINE_PIX / 2);
      clock_step();
    end
    pgl_dvld_i   = 1'b0;
    cu_yc_done_i = 1'b0;
    pgl_hend_i   = 1'b1;
    clock_step();
    pgl_hend_i   = 1'b0;
    repeat (BLANK) clock_step();
    end_test();
  endtask

  task automatic run_frame();
    begin_test("frame start");
    pgl_vstr_i = 1'b1;
    clock_step();
    pgl_vstr_i = 1'b0;
    pgl_fstr_i = 1'b1;
    clock_step();
    pgl_fstr_i = 1'b0;
    repeat (4) clock_step();
    end_test();
    for (int k = 0; k < n_lines; k++)
      run_line(k);
    begin_test("frame end");
    pgl_vend_i = 1'b1;
    clock_step();
    pgl_vend_i = 1'b0;
    repeat (6) clock_step();
    if (pgl_ystr_lft_o !== '0 || pgl_ystr_rgt_o !== '0) begin
      $display("Error at %0t ns: segment index not cleared after frame end", $time);
      test_errs++;
    end
    end_test();
  endtask

  initial begin : watchdog
    wait (n_lines > 0);
    #((n_lines + 2) * LINE_CYC * CLK_NS + 100 * CLK_NS);
    $display("Timeout: the frame did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    init_inputs();
    void'($urandom(89));
    $readmemh("pgl_input.txt", vec);
    n_lines = int'(vec[0]);
    load_tables();
    @(posedge prst_n);
    begin_test("reset");
    check_outputs();                             // Reference is all zero here
    end_test();
    if (n_lines < 1 || n_lines > MAX_REC) begin
      $display("Error: input file gives no usable line count");
      test_fails++;
    end else begin
      run_frame();
    end
    err_total += uut.u_asserts.fails;
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fails, checks_run, err_total);
    if (err_total == 0 && test_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/pgl_ctrl_asserts.sv
`timescale 1ns/1ns

module pgl_ctrl_asserts (
  input logic pclk,
  input logic prst_n,
  input logic pgl_hend_i,
  input logic pgl_hend_o,
  input logic reg_kill_lft_i,
  input logic pgl_vld_lft_o,
  input logic pgl_vld_rgt_o,
  input logic pgl_edge_o
);

  int unsigned fails = 0;                        // Read by the testbench at the end

  // Line end comes out of the two-stage strobe queue
  a_hend_delay: assert property (@(posedge pclk) disable iff (!prst_n)
    pgl_hend_o == $past(pgl_hend_i, 2))
    else begin
      fails++;
      $error("pgl_hend_o does not repeat pgl_hend_i two cycles later");
    end

  // An edge only sits inside some valid window
  a_edge_in_window: assert property (@(posedge pclk) disable iff (!prst_n)
    pgl_edge_o |-> (pgl_vld_lft_o || pgl_vld_rgt_o))
    else begin
      fails++;
      $error("pgl_edge_o high with no side valid");
    end

  a_kill_lft: assert property (@(posedge pclk) disable iff (!prst_n)
    reg_kill_lft_i |-> !pgl_vld_lft_o)
    else begin
      fails++;
      $error("pgl_vld_lft_o high while left line is killed");
    end

endmodule

bind pgl_ctrl pgl_ctrl_asserts u_asserts (
  .pclk           (pclk),
  .prst_n         (prst_n),
  .pgl_hend_i     (pgl_hend_i),
  .pgl_hend_o     (pgl_hend_o),
  .reg_kill_lft_i (reg_kill_lft_i),
  .pgl_vld_lft_o  (pgl_vld_lft_o),
  .pgl_vld_rgt_o  (pgl_vld_rgt_o),
  .pgl_edge_o     (pgl_edge_o)
);

//--- bench/pgl_clk_gen.sv
`timescale 1ns/1ns

module pgl_clk_gen #(
  parameter int PERIOD_NS = 20,
  parameter int RST_CYC   = 3
) (
  output logic pclk,
  output logic prst_n
);

  initial begin
    pclk = 1'b0;
    forever #(PERIOD_NS / 2) pclk = ~pclk;
  end

  initial begin
    prst_n = 1'b0;
    repeat (RST_CYC) @(posedge pclk);
    @(negedge pclk);
    prst_n = 1'b1;                               // Release away from the active edge
  end

endmodule

//--- hdl/pgl_ctrl.sv
`timescale 1ns/1ns
`include "pgl_macros.svh"

module pgl_ctrl (
  input  logic                               pclk,
  input  logic                               prst_n,
  // Sync and data-valid strobes
  input  logic                               pgl_fstr_i,
  input  logic                               pgl_vstr_i,
  input  logic                               pgl_vend_i,
  input  logic                               pgl_hstr_i,
  input  logic                               pgl_hend_i,
  input  logic                               pgl_dvld_i,
  // Calculation unit
  input  logic                               cu_yc_done_i,   // Y-compare task done
  input  logic                               cu_lft_ystr_csgb_i,
  input  logic                               cu_lft_ystr_eq_i,
  input  logic                               cu_lft_yend_csgb_i,
  input  logic                               cu_lft_yend_eq_i,
  input  pgl_pkg::pgl_hcnt_t                 cu_lft_xstr_i,
  input  pgl_pkg::pgl_hcnt_t                 cu_lft_xend_i,
  input  logic                               cu_rgt_ystr_csgb_i,
  input  logic                               cu_rgt_ystr_eq_i,
  input  logic                               cu_rgt_yend_csgb_i,
  input  logic                               cu_rgt_yend_eq_i,
  input  pgl_pkg::pgl_hcnt_t                 cu_rgt_xstr_i,
  input  pgl_pkg::pgl_hcnt_t                 cu_rgt_xend_i,
  // Segment tables
  input  pgl_pkg::pgl_ystr_t [`PGL_SEG-1:0]  reg_ystr_lft_i,
  input  pgl_pkg::pgl_h_t    [`PGL_SEG-1:0]  reg_h_lft_i,
  input  pgl_pkg::pgl_ystr_t [`PGL_SEG-1:0]  reg_ystr_rgt_i,
  input  pgl_pkg::pgl_h_t    [`PGL_SEG-1:0]  reg_h_rgt_i,
  input  pgl_pkg::pgl_code_t [`PGL_SEG-1:0]  reg_type_i,      // Shared by both sides
  input  pgl_pkg::pgl_code_t [`PGL_SEG-1:0]  reg_colr_i,
  input  logic                               reg_kill_lft_i,  // Erase left line
  input  logic                               reg_kill_rgt_i,  // Erase right line
  // Delayed strobes and counters
  output logic                               pgl_vstr_o,
  output logic                               pgl_vend_o,
  output logic                               pgl_hstr_o,
  output logic                               pgl_hend_o,
  output logic                               pgl_dvld_o,
  output pgl_pkg::pgl_hcnt_t                 pgl_hcnt_o,
  output pgl_pkg::pgl_vcnt_t                 pgl_vcnt_o,
  // Per-side segment data
  output pgl_pkg::pgl_ystr_t                 pgl_ystr_lft_o,
  output pgl_pkg::pgl_h_t                    pgl_h_lft_o,
  output pgl_pkg::pgl_code_t                 pgl_type_lft_o,
  output pgl_pkg::pgl_code_t                 pgl_colr_lft_o,
  output pgl_pkg::pgl_ystr_t                 pgl_ystr_rgt_o,
  output pgl_pkg::pgl_h_t                    pgl_h_rgt_o,
  output pgl_pkg::pgl_code_t                 pgl_type_rgt_o,
  output pgl_pkg::pgl_code_t                 pgl_colr_rgt_o,
  // Overlay control
  output logic                               pgl_vld_lft_o,
  output logic                               pgl_vld_rgt_o,
  output logic                               pgl_edge_o
);

  import pgl_pkg::*;

  pgl_cu_side_t cu_lft;                          // Packed CU result, left
  pgl_cu_side_t cu_rgt;                          // Packed CU result, right

  pgl_sync_if sync_if ();

  // ----------------------------------------
  // CU result packing
  // ----------------------------------------
  assign cu_lft = '{ystr_csgb: cu_lft_ystr_csgb_i, ystr_eq: cu_lft_ystr_eq_i,
                    yend_csgb: cu_lft_yend_csgb_i, xstr: cu_lft_xstr_i,
                    xend: cu_lft_xend_i};
  assign cu_rgt = '{ystr_csgb: cu_rgt_ystr_csgb_i, ystr_eq: cu_rgt_ystr_eq_i,
                    yend_csgb: cu_rgt_yend_csgb_i, xstr: cu_rgt_xstr_i,
                    xend: cu_rgt_xend_i};

  pgl_timing u_timing (
    .prst_n, .pclk, .pgl_fstr_i, .pgl_vstr_i, .pgl_vend_i, .pgl_hstr_i,
    .pgl_hend_i, .pgl_dvld_i, .pgl_vstr_o, .pgl_vend_o, .pgl_hstr_o,
    .pgl_hend_o, .pgl_dvld_o, .pgl_hcnt_o, .pgl_vcnt_o,
    .sync (sync_if.src)
  );

  // Segment trackers, advanced when CU sees the segment end row
  pgl_seg_track u_seg_lft (
    .prst_n, .pclk, .sync (sync_if.sink),
    .seg_adv_i  (cu_yc_done_i & cu_lft_yend_eq_i),
    .tbl_ystr_i (reg_ystr_lft_i), .tbl_h_i (reg_h_lft_i),
    .tbl_type_i (reg_type_i), .tbl_colr_i (reg_colr_i),
    .ystr_o (pgl_ystr_lft_o), .h_o (pgl_h_lft_o),
    .type_o (pgl_type_lft_o), .colr_o (pgl_colr_lft_o)
  );

  pgl_seg_track u_seg_rgt (
    .prst_n, .pclk, .sync (sync_if.sink),
    .seg_adv_i  (cu_yc_done_i & cu_rgt_yend_eq_i),
    .tbl_ystr_i (reg_ystr_rgt_i), .tbl_h_i (reg_h_rgt_i),
    .tbl_type_i (reg_type_i), .tbl_colr_i (reg_colr_i),
    .ystr_o (pgl_ystr_rgt_o), .h_o (pgl_h_rgt_o),
    .type_o (pgl_type_rgt_o), .colr_o (pgl_colr_rgt_o)
  );

  pgl_window u_window (
    .prst_n, .pclk, .sync (sync_if.sink),
    .cu_lft_i (cu_lft), .cu_rgt_i (cu_rgt),
    .type_lft_i (pgl_type_lft_o), .type_rgt_i (pgl_type_rgt_o),
    .kill_lft_i (reg_kill_lft_i), .kill_rgt_i (reg_kill_rgt_i),
    .vld_lft_o (pgl_vld_lft_o), .vld_rgt_o (pgl_vld_rgt_o),
    .edge_o (pgl_edge_o)
  );

endmodule

//--- hdl/pgl_window.sv
`timescale 1ns/1ns

module pgl_window (
  input  logic                   prst_n,
  input  logic                   pclk,
  pgl_sync_if.sink               sync,
  input  pgl_pkg::pgl_cu_side_t  cu_lft_i,
  input  pgl_pkg::pgl_cu_side_t  cu_rgt_i,
  input  pgl_pkg::pgl_code_t     type_lft_i,
  input  pgl_pkg::pgl_code_t     type_rgt_i,
  input  logic                   kill_lft_i,
  input  logic                   kill_rgt_i,
  output logic                   vld_lft_o,
  output logic                   vld_rgt_o,
  output logic                   edge_o
);

  import pgl_pkg::*;

  localparam int LFT = 0;
  localparam int RGT = 1;

  pgl_cu_side_t cu_in [2];                       // Live CU results
  pgl_cu_side_t cap   [2];                       // Results held for current line
  pgl_code_t    ln_type [2];
  logic [1:0]   kill;
  logic [1:0]   vld;
  logic [1:0]   xstr_eq;                         // hcnt on x-start
  logic [1:0]   xend_eq;                         // hcnt on x-end
  logic         edge_lft;
  logic         edge_rgt;

  assign cu_in[LFT]   = cu_lft_i;
  assign cu_in[RGT]   = cu_rgt_i;
  assign ln_type[LFT] = type_lft_i;
  assign ln_type[RGT] = type_rgt_i;
  assign kill         = {kill_rgt_i, kill_lft_i};

  // ----------------------------------------
  // CU result capture
  // ----------------------------------------
  // CU works one line ahead, so results land at hend
  always_ff @(posedge pclk or negedge prst_n) begin
    if (!prst_n) begin
      cap[LFT] <= '0;
      cap[RGT] <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (sync.hend)
          cap[s] <= cu_in[s];
        if (sync.fstr) begin                     // No segment open at frame start
          cap[s].ystr_eq   <= 1'b0;
          cap[s].yend_csgb <= 1'b0;
        end
      end
    end
  end

  // Valid window per side
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      xstr_eq[s] = sync.hcnt == cap[s].xstr;
      xend_eq[s] = sync.hcnt == cap[s].xend;
      vld[s]     = ~kill[s] & (ln_type[s] != '0) &
                   ~cap[s].ystr_csgb & (cap[s].yend_csgb | cap[s].ystr_eq) &
                   (sync.hcnt >= cap[s].xstr) & (sync.hcnt <= cap[s].xend);
    end
  end

  // ----------------------------------------
  // Line edges, inner bounds masked on overlap
  // ----------------------------------------
  assign edge_lft = (xstr_eq[LFT] | (xend_eq[LFT] & ~vld[RGT])) & vld[LFT];
  assign edge_rgt = ((xstr_eq[RGT] & ~vld[LFT]) | xend_eq[RGT]) & vld[RGT];

  assign edge_o    = edge_lft | edge_rgt;
  assign vld_lft_o = vld[LFT];
  assign vld_rgt_o = vld[RGT];

endmodule

//--- hdl/pgl_seg_track.sv
`timescale 1ns/1ns
`include "pgl_macros.svh"

module pgl_seg_track (
  input  logic                                  prst_n,
  input  logic                                  pclk,
  pgl_sync_if.sink                              sync,
  input  logic                                  seg_adv_i,   // Segment end reached
  input  pgl_pkg::pgl_ystr_t [`PGL_SEG-1:0]     tbl_ystr_i,
  input  pgl_pkg::pgl_h_t    [`PGL_SEG-1:0]     tbl_h_i,
  input  pgl_pkg::pgl_code_t [`PGL_SEG-1:0]     tbl_type_i,
  input  pgl_pkg::pgl_code_t [`PGL_SEG-1:0]     tbl_colr_i,
  output pgl_pkg::pgl_ystr_t                    ystr_o,
  output pgl_pkg::pgl_h_t                       h_o,
  output pgl_pkg::pgl_code_t                    type_o,
  output pgl_pkg::pgl_code_t                    colr_o
);

  import pgl_pkg::*;

  pgl_seg_oh_t seg_idx;                          // Current dash segment
  pgl_code_t   type_sel;                         // Table type for seg_idx
  pgl_code_t   colr_sel;                         // Table color for seg_idx
  pgl_code_t   ln_type;                          // Type one cycle behind selection

  // ----------------------------------------
  // One-hot segment index
  // ----------------------------------------
  always_ff @(posedge pclk or negedge prst_n) begin
    if (!prst_n) begin
      seg_idx <= '0;
    end else begin
      seg_idx[0] <= sync.fstr | (seg_idx[0] & ~seg_adv_i & ~sync.vend_d);
      if (sync.vend_d)
        seg_idx[`PGL_SEG-1:1] <= '0;             // Frame done
      else if (seg_adv_i)
        seg_idx[`PGL_SEG-1:1] <= seg_idx[`PGL_SEG-2:0];
    end
  end

  // Table selection, AND-OR over the one-hot index
  always_comb begin
    ystr_o   = '0;
    h_o      = '0;
    type_sel = '0;
    colr_sel = '0;
    for (int i = 0; i < `PGL_SEG; i++) begin
      if (seg_idx[i]) begin
        ystr_o   = ystr_o | tbl_ystr_i[i];
        h_o      = h_o | tbl_h_i[i];
        type_sel = type_sel | tbl_type_i[i];
        colr_sel = colr_sel | tbl_colr_i[i];
      end
    end
  end

  // Type and color held for the whole next line
  always_ff @(posedge pclk or negedge prst_n) begin
    if (!prst_n) begin
      ln_type <= '0;
      type_o  <= '0;
      colr_o  <= '0;
    end else begin
      ln_type <= type_sel;
      if (sync.hend) begin
        type_o <= ln_type;
        colr_o <= colr_sel;
      end
    end
  end

endmodule

//--- hdl/pgl_timing.sv
`timescale 1ns/1ns

module pgl_timing (
  input  logic                prst_n,
  input  logic                pclk,
  input  logic                pgl_fstr_i,
  input  logic                pgl_vstr_i,
  input  logic                pgl_vend_i,
  input  logic                pgl_hstr_i,
  input  logic                pgl_hend_i,
  input  logic                pgl_dvld_i,
  output logic                pgl_vstr_o,
  output logic                pgl_vend_o,
  output logic                pgl_hstr_o,
  output logic                pgl_hend_o,
  output logic                pgl_dvld_o,
  output pgl_pkg::pgl_hcnt_t  pgl_hcnt_o,
  output pgl_pkg::pgl_vcnt_t  pgl_vcnt_o,
  pgl_sync_if.src             sync
);

  import pgl_pkg::*;

  logic [4:0] strb_in;                           // {vstr, vend, hstr, hend, dvld}
  logic [4:0] strb_d1;                           // First queue stage
  logic [4:0] strb_d2;                           // Second queue stage
  pgl_hcnt_t  cnt_mux;                           // Counter picked for the adder
  pgl_hcnt_t  cnt_inc;                           // Shared incrementer result
  logic       hcnt_clr;
  logic       hcnt_inc;

  // ----------------------------------------
  // Strobe delay queues
  // ----------------------------------------
  assign strb_in = {pgl_vstr_i, pgl_vend_i, pgl_hstr_i, pgl_hend_i, pgl_dvld_i};

  assign {pgl_vstr_o, pgl_vend_o, pgl_hstr_o, pgl_hend_o, pgl_dvld_o} = strb_d2;

  // H/V counters share one adder, v-counter wins on hstr
  assign cnt_mux  = pgl_hstr_i ? pgl_vcnt_o : pgl_hcnt_o;
  assign cnt_inc  = cnt_mux + 1'b1;
  assign hcnt_clr = pgl_hstr_i | strb_d1[4];     // Line start or vstr one cycle late
  assign hcnt_inc = pgl_dvld_i | strb_d1[0];     // Stretched by one cycle

  always_ff @(posedge pclk or negedge prst_n) begin
    if (!prst_n) begin
      strb_d1    <= '0;
      strb_d2    <= '0;
      pgl_hcnt_o <= '0;
      pgl_vcnt_o <= '0;
    end else begin
      strb_d1 <= strb_in;
      strb_d2 <= strb_d1;
      if (hcnt_clr)
        pgl_hcnt_o <= '0;
      else if (hcnt_inc)
        pgl_hcnt_o <= cnt_inc;
      if (strb_d1[4])                            // Frame restart
        pgl_vcnt_o <= '0;
      else if (pgl_hstr_i)
        pgl_vcnt_o <= cnt_inc;
    end
  end

  // Line timing for the downstream blocks
  assign sync.fstr   = pgl_fstr_i;
  assign sync.hend   = pgl_hend_i;
  assign sync.vend_d = strb_d2[3];
  assign sync.hcnt   = pgl_hcnt_o;

endmodule

//--- hdl/pgl_sync_if.sv
`timescale 1ns/1ns

interface pgl_sync_if;

  import pgl_pkg::*;

  logic      fstr;                               // Frame start, undelayed
  logic      hend;                               // Line end, undelayed
  logic      vend_d;                             // Frame end after strobe queue
  pgl_hcnt_t hcnt;                               // Shared h-counter

  // Timing block side
  modport src (
    output fstr, hend, vend_d, hcnt
  );

  // Segment tracker and window side
  modport sink (
    input  fstr, hend, vend_d, hcnt
  );

endinterface

//--- hdl/pgl_pkg.sv
`include "pgl_macros.svh"

package pgl_pkg;

  // ----------------------------------------
  // Segment table fields
  // ----------------------------------------
  typedef logic [`PGL_YSTR_W-1:0] pgl_ystr_t;    // Segment y-start
  typedef logic [`PGL_H_W-1:0]    pgl_h_t;       // Segment height
  typedef logic [`PGL_CODE_W-1:0] pgl_code_t;    // Type 0 is no line, bit 1 is horizontal
  typedef logic [`PGL_SEG-1:0]    pgl_seg_oh_t;  // One-hot segment index

  // Pixel counters
  typedef logic [`PGL_XWID-1:0]   pgl_hcnt_t;
  typedef logic [`PGL_YWID-1:0]   pgl_vcnt_t;

  // ----------------------------------------
  // Per-side calculation-unit result
  // ----------------------------------------
  typedef struct packed {
    logic      ystr_csgb;                        // Row before segment start
    logic      ystr_eq;                          // Row on segment start
    logic      yend_csgb;                        // Row before segment end
    pgl_hcnt_t xstr;                             // Line x-start
    pgl_hcnt_t xend;                             // Line x-end
  } pgl_cu_side_t;

endpackage

//--- include/pgl_macros.svh
`ifndef PGL_MACROS_SVH
`define PGL_MACROS_SVH

// Counter widths
`define PGL_XWID    10
`define PGL_YWID    10

// Dash-segment table geometry
`define PGL_SEG     10
`define PGL_YSTR_W  8
`define PGL_H_W     6
`define PGL_CODE_W  2

`endif
